// ==== src/axi_pkg.sv ====
`default_nettype none

package axi_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;
    localparam int ID_W   = 4;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_DECERR = 2'b11;

    // Single-beat word transfer, incrementing burst
    localparam logic [7:0] LEN_SINGLE = 8'd0;
    localparam logic [2:0] SIZE_WORD  = 3'd2;
    localparam logic [1:0] BURST_INCR = 2'b01;

    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [ADDR_W-1:0] addr;
        logic [7:0]        len;
        logic [2:0]        size;
        logic [1:0]        burst;
    } axi_aw_t;

    // Read address has the same layout as write address
    typedef axi_aw_t axi_ar_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
        logic              last;
    } axi_w_t;

    typedef struct packed {
        logic [ID_W-1:0] id;
        logic [1:0]      resp;
    } axi_b_t;

    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [DATA_W-1:0] data;
        logic [1:0]        resp;
        logic              last;
    } axi_r_t;

endpackage

`default_nettype wire

// ==== src/dram_pkg.sv ====
`default_nettype none

package dram_pkg;

    localparam int COL_W  = 10;
    localparam int BANK_W = 3;
    localparam int ROW_W  = 14;

    // Byte address split of a word access
    localparam int COL_LSB  = 2;
    localparam int BANK_LSB = COL_LSB + COL_W;
    localparam int ROW_LSB  = BANK_LSB + BANK_W;

    // Everything below this is DRAM
    localparam logic [31:0] DRAM_LIMIT = 32'h2000_0000;

    // Command gaps in clock cycles
    localparam int T_RCD = 2;
    localparam int T_CL  = 3;
    localparam int T_WR  = 2;
    localparam int T_RP  = 2;

    localparam int CNT_W = 3;

    // Levels on {cs, ras, cas, we}, all active low
    typedef enum logic [3:0] {
        CMD_NOP       = 4'b1111,
        CMD_ACTIVATE  = 4'b0011,
        CMD_READ      = 4'b0101,
        CMD_WRITE     = 4'b0100,
        CMD_PRECHARGE = 4'b0010
    } dram_cmd_t;

endpackage

`default_nettype wire

// ==== src/mem_axi_bridge.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_axi_bridge
    import axi_pkg::*;
(
    input  wire               clk,
    input  wire               rst_n,
    input  wire               mem_valid,
    input  wire [ADDR_W-1:0]  mem_addr,
    input  wire [DATA_W-1:0]  mem_wdata,
    input  wire [STRB_W-1:0]  mem_wstrb,
    output logic              mem_ready,
    output logic [DATA_W-1:0] mem_rdata,
    output logic              mem_error,
    output axi_aw_t           aw,
    output logic              aw_valid,
    input  wire               aw_ready,
    output axi_w_t            w,
    output logic              w_valid,
    input  wire               w_ready,
    input  wire axi_b_t       b,
    input  wire               b_valid,
    output logic              b_ready,
    output axi_ar_t           ar,
    output logic              ar_valid,
    input  wire               ar_ready,
    input  wire axi_r_t       r,
    input  wire               r_valid,
    output logic              r_ready
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_ADDR,
        S_RESP,
        S_DONE
    } state_t;

    state_t state;
    logic   is_write;
    logic   aw_left;
    logic   w_left;
    logic   ar_left;
    logic   rsp_fire;

    // Request is held until mem_ready, so payloads come straight from it
    assign aw = '{id: '0, addr: {mem_addr[ADDR_W-1:2], 2'b00}, len: LEN_SINGLE,
                  size: SIZE_WORD, burst: BURST_INCR};
    assign ar = aw;
    assign w  = '{data: mem_wdata, strb: mem_wstrb, last: 1'b1};

    // Channels still waiting for their handshake
    assign aw_left = aw_valid && !aw_ready;
    assign w_left  = w_valid && !w_ready;
    assign ar_left = ar_valid && !ar_ready;

    assign b_ready   = (state == S_RESP) && is_write;
    assign r_ready   = (state == S_RESP) && !is_write;
    assign rsp_fire  = (b_ready && b_valid) || (r_ready && r_valid);
    assign mem_ready = (state == S_DONE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= S_IDLE;
            is_write <= 1'b0;
            aw_valid <= 1'b0;
            w_valid  <= 1'b0;
            ar_valid <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (mem_valid) begin
                        is_write <= |mem_wstrb;
                        aw_valid <= |mem_wstrb;
                        w_valid  <= |mem_wstrb;
                        ar_valid <= ~|mem_wstrb;
                        state    <= S_ADDR;
                    end
                end
                S_ADDR: begin
                    // AW and W may be taken in different cycles
                    aw_valid <= aw_left;
                    w_valid  <= w_left;
                    ar_valid <= ar_left;
                    if (!aw_left && !w_left && !ar_left) begin
                        state <= S_RESP;
                    end
                end
                S_RESP: begin
                    if (rsp_fire) begin
                        state <= S_DONE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Result shown during the mem_ready cycle
    always_ff @(posedge clk) begin
        if (rsp_fire) begin
            mem_rdata <= is_write ? '0 : r.data;
            mem_error <= (is_write ? b.resp : r.resp) != RESP_OKAY;
        end
    end

endmodule

`default_nettype wire

// ==== src/axi_interconnect.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_interconnect
    import axi_pkg::*;
    import dram_pkg::*;
(
    input  wire         clk,
    input  wire         rst_n,
    // From the bridge
    input  wire axi_aw_t s_aw,
    input  wire         s_aw_valid,
    output logic        s_aw_ready,
    input  wire axi_w_t s_w,
    input  wire         s_w_valid,
    output logic        s_w_ready,
    output axi_b_t      s_b,
    output logic        s_b_valid,
    input  wire         s_b_ready,
    input  wire axi_ar_t s_ar,
    input  wire         s_ar_valid,
    output logic        s_ar_ready,
    output axi_r_t      s_r,
    output logic        s_r_valid,
    input  wire         s_r_ready,
    // To the DRAM controller
    output axi_aw_t     m_aw,
    output logic        m_aw_valid,
    input  wire         m_aw_ready,
    output axi_w_t      m_w,
    output logic        m_w_valid,
    input  wire         m_w_ready,
    input  wire axi_b_t m_b,
    input  wire         m_b_valid,
    output logic        m_b_ready,
    output axi_ar_t     m_ar,
    output logic        m_ar_valid,
    input  wire         m_ar_ready,
    input  wire axi_r_t m_r,
    input  wire         m_r_valid,
    output logic        m_r_ready
);

    logic            aw_dram;
    logic            ar_dram;
    logic            err_aw_take;
    logic            err_ar_take;
    logic            err_b_valid;
    logic            err_r_valid;
    logic [ID_W-1:0] err_bid;
    logic [ID_W-1:0] err_rid;

    assign aw_dram = (s_aw.addr < DRAM_LIMIT);
    assign ar_dram = (s_ar.addr < DRAM_LIMIT);

    // DRAM requests pass through with no added latency
    assign m_aw       = s_aw;
    assign m_aw_valid = s_aw_valid && aw_dram;
    // W follows the AW next to it, both targets take the pair in one cycle
    assign m_w        = s_w;
    assign m_w_valid  = s_w_valid && aw_dram;
    assign m_ar       = s_ar;
    assign m_ar_valid = s_ar_valid && ar_dram;

    // Error responder takes one request per direction at a time
    assign err_aw_take = s_aw_valid && s_w_valid && !aw_dram && !err_b_valid;
    assign err_ar_take = s_ar_valid && !ar_dram && !err_r_valid;

    assign s_aw_ready = aw_dram ? m_aw_ready : err_aw_take;
    assign s_w_ready  = aw_dram ? m_w_ready : err_aw_take;
    assign s_ar_ready = ar_dram ? m_ar_ready : err_ar_take;

    // A pending error response owns the return channel
    assign s_b_valid = err_b_valid || m_b_valid;
    assign s_b       = err_b_valid ? axi_b_t'{id: err_bid, resp: RESP_DECERR} : m_b;
    assign m_b_ready = s_b_ready && !err_b_valid;

    assign s_r_valid = err_r_valid || m_r_valid;
    assign s_r       = err_r_valid
                     ? axi_r_t'{id: err_rid, data: '0, resp: RESP_DECERR, last: 1'b1}
                     : m_r;
    assign m_r_ready = s_r_ready && !err_r_valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            err_b_valid <= 1'b0;
            err_r_valid <= 1'b0;
        end else begin
            if (err_aw_take) begin
                err_b_valid <= 1'b1;
            end else if (s_b_ready) begin
                err_b_valid <= 1'b0;
            end
            if (err_ar_take) begin
                err_r_valid <= 1'b1;
            end else if (s_r_ready) begin
                err_r_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (err_aw_take) begin
            err_bid <= s_aw.id;
        end
        if (err_ar_take) begin
            err_rid <= s_ar.id;
        end
    end

endmodule

`default_nettype wire

// ==== src/dram_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module dram_controller
    import axi_pkg::*;
    import dram_pkg::*;
(
    input  wire               clk,
    input  wire               rst_n,
    input  wire axi_aw_t      aw,
    input  wire               aw_valid,
    output logic              aw_ready,
    input  wire axi_w_t       w,
    input  wire               w_valid,
    output logic              w_ready,
    output axi_b_t            b,
    output logic              b_valid,
    input  wire               b_ready,
    input  wire axi_ar_t      ar,
    input  wire               ar_valid,
    output logic              ar_ready,
    output axi_r_t            r,
    output logic              r_valid,
    input  wire               r_ready,
    output logic              dram_ck,
    output logic              dram_cs,
    output logic              dram_ras,
    output logic              dram_cas,
    output logic              dram_we,
    output logic [ROW_W-1:0]  dram_addr,
    output logic [BANK_W-1:0] dram_ba,
    inout  wire  [DATA_W-1:0] dram_dq,
    output logic [STRB_W-1:0] dram_dm
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_ACT,
        ST_RCD,
        ST_RW,
        ST_CAS,
        ST_WR,
        ST_PRE,
        ST_RP
    } state_t;

    state_t            state;
    logic [CNT_W-1:0]  cnt;
    logic              cnt_zero;
    logic              take_rd;
    logic              take_wr;
    logic [ADDR_W-1:0] req_addr;
    logic              is_write;
    logic [ROW_W-1:0]  row;
    logic [BANK_W-1:0] bank;
    logic [COL_W-1:0]  col;
    logic [ID_W-1:0]   req_id;
    logic [DATA_W-1:0] wdata;
    logic [STRB_W-1:0] wstrb;
    logic [DATA_W-1:0] rdata;
    logic              wr_beat;
    dram_cmd_t         cmd;

    // Nothing new until the last response is gone and tRP has run out
    assign take_rd  = (state == ST_IDLE) && !b_valid && !r_valid && ar_valid;
    assign take_wr  = (state == ST_IDLE) && !b_valid && !r_valid && !ar_valid
                      && aw_valid && w_valid;
    assign ar_ready = take_rd;
    assign aw_ready = take_wr;
    assign w_ready  = take_wr;
    assign req_addr = take_rd ? ar.addr : aw.addr;
    assign cnt_zero = (cnt == '0);

    always_ff @(posedge clk) begin
        if (take_rd || take_wr) begin
            row    <= req_addr[ROW_LSB +: ROW_W];
            bank   <= req_addr[BANK_LSB +: BANK_W];
            col    <= req_addr[COL_LSB +: COL_W];
            req_id <= take_rd ? ar.id : aw.id;
            wdata  <= w.data;
            wstrb  <= w.strb;
        end
        // Sample T_CL cycles after READ
        if (state == ST_CAS && cnt_zero) begin
            rdata <= dram_dq;
        end
    end

    // Closed page sequencer, one countdown shared by every wait
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= ST_IDLE;
            cnt      <= '0;
            is_write <= 1'b0;
            b_valid  <= 1'b0;
            r_valid  <= 1'b0;
        end else begin
            if (!cnt_zero) begin
                cnt <= cnt - 1'b1;
            end
            if (b_valid && b_ready) begin
                b_valid <= 1'b0;
            end
            if (r_valid && r_ready) begin
                r_valid <= 1'b0;
            end
            case (state)
                ST_IDLE: begin
                    if (take_rd || take_wr) begin
                        is_write <= take_wr;
                        state    <= ST_ACT;
                    end
                end
                ST_ACT: begin
                    cnt   <= CNT_W'(T_RCD - 2);
                    state <= ST_RCD;
                end
                ST_RCD: begin
                    if (cnt_zero) begin
                        state <= ST_RW;
                    end
                end
                ST_RW: begin
                    if (is_write) begin
                        b_valid <= 1'b1;
                        cnt     <= CNT_W'(T_WR - 2);
                        state   <= ST_WR;
                    end else begin
                        cnt   <= CNT_W'(T_CL - 1);
                        state <= ST_CAS;
                    end
                end
                ST_CAS: begin
                    if (cnt_zero) begin
                        r_valid <= 1'b1;
                        state   <= ST_PRE;
                    end
                end
                ST_WR: begin
                    if (cnt_zero) begin
                        state <= ST_PRE;
                    end
                end
                ST_PRE: begin
                    cnt   <= CNT_W'(T_RP - 2);
                    state <= ST_RP;
                end
                default: begin
                    if (cnt_zero) begin
                        state <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    always_comb begin
        case (state)
            ST_ACT:  cmd = CMD_ACTIVATE;
            ST_RW:   cmd = is_write ? CMD_WRITE : CMD_READ;
            ST_PRE:  cmd = CMD_PRECHARGE;
            default: cmd = CMD_NOP;
        endcase
    end

    assign wr_beat = (state == ST_RW) && is_write;

    assign dram_ck = clk;
    assign {dram_cs, dram_ras, dram_cas, dram_we} = cmd;
    // Row with ACTIVATE, column with READ and WRITE
    assign dram_addr = (state == ST_ACT) ? row : ROW_W'(col);
    assign dram_ba   = bank;
    assign dram_dq   = wr_beat ? wdata : {DATA_W{1'bz}};
    assign dram_dm   = wr_beat ? ~wstrb : '0;

    assign b = '{id: req_id, resp: RESP_OKAY};
    assign r = '{id: req_id, data: rdata, resp: RESP_OKAY, last: 1'b1};

endmodule

`default_nettype wire

// ==== src/soc_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module soc_top
    import axi_pkg::*;
    import dram_pkg::*;
(
    input  wire               clk,
    input  wire               rst_n,
    // Processor memory port
    input  wire               mem_valid,
    input  wire [ADDR_W-1:0]  mem_addr,
    input  wire [DATA_W-1:0]  mem_wdata,
    input  wire [STRB_W-1:0]  mem_wstrb,
    output wire               mem_ready,
    output wire [DATA_W-1:0]  mem_rdata,
    output wire               mem_error,
    // DRAM pins
    output wire               dram_ck,
    output wire               dram_cs,
    output wire               dram_ras,
    output wire               dram_cas,
    output wire               dram_we,
    output wire [ROW_W-1:0]   dram_addr,
    output wire [BANK_W-1:0]  dram_ba,
    inout  wire [DATA_W-1:0]  dram_dq,
    output wire [STRB_W-1:0]  dram_dm
);

    // Bridge to interconnect
    axi_aw_t cpu_aw;
    axi_w_t  cpu_w;
    axi_b_t  cpu_b;
    axi_ar_t cpu_ar;
    axi_r_t  cpu_r;
    logic    cpu_aw_valid, cpu_aw_ready;
    logic    cpu_w_valid, cpu_w_ready;
    logic    cpu_b_valid, cpu_b_ready;
    logic    cpu_ar_valid, cpu_ar_ready;
    logic    cpu_r_valid, cpu_r_ready;

    // Interconnect to DRAM controller
    axi_aw_t dram_s_aw;
    axi_w_t  dram_s_w;
    axi_b_t  dram_s_b;
    axi_ar_t dram_s_ar;
    axi_r_t  dram_s_r;
    logic    dram_s_aw_valid, dram_s_aw_ready;
    logic    dram_s_w_valid, dram_s_w_ready;
    logic    dram_s_b_valid, dram_s_b_ready;
    logic    dram_s_ar_valid, dram_s_ar_ready;
    logic    dram_s_r_valid, dram_s_r_ready;

    mem_axi_bridge cpu_axi_master (
        .clk(clk), .rst_n(rst_n),
        .mem_valid(mem_valid), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_wstrb(mem_wstrb),
        .mem_ready(mem_ready), .mem_rdata(mem_rdata), .mem_error(mem_error),
        .aw(cpu_aw), .aw_valid(cpu_aw_valid), .aw_ready(cpu_aw_ready),
        .w(cpu_w), .w_valid(cpu_w_valid), .w_ready(cpu_w_ready),
        .b(cpu_b), .b_valid(cpu_b_valid), .b_ready(cpu_b_ready),
        .ar(cpu_ar), .ar_valid(cpu_ar_valid), .ar_ready(cpu_ar_ready),
        .r(cpu_r), .r_valid(cpu_r_valid), .r_ready(cpu_r_ready)
    );

    axi_interconnect axi_interconnect_inst (
        .clk(clk), .rst_n(rst_n),
        .s_aw(cpu_aw), .s_aw_valid(cpu_aw_valid), .s_aw_ready(cpu_aw_ready),
        .s_w(cpu_w), .s_w_valid(cpu_w_valid), .s_w_ready(cpu_w_ready),
        .s_b(cpu_b), .s_b_valid(cpu_b_valid), .s_b_ready(cpu_b_ready),
        .s_ar(cpu_ar), .s_ar_valid(cpu_ar_valid), .s_ar_ready(cpu_ar_ready),
        .s_r(cpu_r), .s_r_valid(cpu_r_valid), .s_r_ready(cpu_r_ready),
        .m_aw(dram_s_aw), .m_aw_valid(dram_s_aw_valid), .m_aw_ready(dram_s_aw_ready),
        .m_w(dram_s_w), .m_w_valid(dram_s_w_valid), .m_w_ready(dram_s_w_ready),
        .m_b(dram_s_b), .m_b_valid(dram_s_b_valid), .m_b_ready(dram_s_b_ready),
        .m_ar(dram_s_ar), .m_ar_valid(dram_s_ar_valid), .m_ar_ready(dram_s_ar_ready),
        .m_r(dram_s_r), .m_r_valid(dram_s_r_valid), .m_r_ready(dram_s_r_ready)
    );

    dram_controller dram_controller_inst (
        .clk(clk), .rst_n(rst_n),
        .aw(dram_s_aw), .aw_valid(dram_s_aw_valid), .aw_ready(dram_s_aw_ready),
        .w(dram_s_w), .w_valid(dram_s_w_valid), .w_ready(dram_s_w_ready),
        .b(dram_s_b), .b_valid(dram_s_b_valid), .b_ready(dram_s_b_ready),
        .ar(dram_s_ar), .ar_valid(dram_s_ar_valid), .ar_ready(dram_s_ar_ready),
        .r(dram_s_r), .r_valid(dram_s_r_valid), .r_ready(dram_s_r_ready),
        .dram_ck(dram_ck),
        .dram_cs(dram_cs), .dram_ras(dram_ras), .dram_cas(dram_cas), .dram_we(dram_we),
        .dram_addr(dram_addr), .dram_ba(dram_ba),
        .dram_dq(dram_dq), .dram_dm(dram_dm)
    );

endmodule

`default_nettype wire

// ==== bench/dram_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module dram_model
    import axi_pkg::*;
    import dram_pkg::*;
(
    input  wire               dram_ck,
    input  wire               rst_n,
    input  wire               dram_cs,
    input  wire               dram_ras,
    input  wire               dram_cas,
    input  wire               dram_we,
    input  wire [ROW_W-1:0]   dram_addr,
    input  wire [BANK_W-1:0]  dram_ba,
    inout  wire [DATA_W-1:0]  dram_dq,
    input  wire [STRB_W-1:0]  dram_dm,
    output int                violations,
    output int                act_count
);

    localparam int KEY_W   = ROW_W + BANK_W + COL_W;
    localparam int N_BANKS = 2 ** BANK_W;

    // Sparse word store, a word never written reads as zero
    logic [DATA_W-1:0] store [logic [KEY_W-1:0]];
    logic [ROW_W-1:0]  open_row [N_BANKS];
    logic              bank_open [N_BANKS];
    int                act_cyc [N_BANKS];
    int                cyc = 0;
    int                pre_cyc = -100;
    int                wr_cyc = -100;
    logic              rst_q = 1'b1;
    int                rd_pend = 0;
    logic [DATA_W-1:0] rd_word = '0;
    logic [KEY_W-1:0]  key;
    logic [DATA_W-1:0] word;

    initial begin
        violations = 0;
        act_count  = 0;
        for (int i = 0; i < N_BANKS; i++) begin
            bank_open[i] = 1'b0;
            act_cyc[i]   = -100;
        end
    end

    // Read data sits on dq for one cycle, T_CL edges after READ
    assign dram_dq = (rd_pend == 1) ? rd_word : {DATA_W{1'bz}};

    task automatic report_violation(input string what);
        $display("DRAM protocol violation at %0d ns: %s", $time, what);
        violations++;
    endtask

    task automatic check_access();
        if (!bank_open[dram_ba]) begin
            report_violation("READ or WRITE to a bank with no open row");
        end else if (cyc - act_cyc[dram_ba] < T_RCD) begin
            report_violation("READ or WRITE less than tRCD after ACTIVATE");
        end
    endtask

    always @(posedge dram_ck) begin
        cyc++;
        if (rd_pend != 0) begin
            rd_pend <= rd_pend - 1;
        end
        // Pins rest at NOP during reset and on the first edge after it
        if (!rst_q && dram_cs !== 1'b1) begin
            report_violation("command pins not at NOP around reset");
        end
        rst_q = rst_n;
        key = {open_row[dram_ba], dram_ba, dram_addr[COL_W-1:0]};
        if (dram_cs === 1'b0) begin
            case ({dram_cs, dram_ras, dram_cas, dram_we})
                CMD_ACTIVATE: begin
                    act_count++;
                    if (bank_open[dram_ba]) begin
                        report_violation("ACTIVATE to a bank that is already open");
                    end
                    if (cyc - pre_cyc < T_RP) begin
                        report_violation("ACTIVATE less than tRP after PRECHARGE");
                    end
                    bank_open[dram_ba] = 1'b1;
                    open_row[dram_ba]  = dram_addr;
                    act_cyc[dram_ba]   = cyc;
                end
                CMD_READ: begin
                    check_access();
                    rd_word <= store.exists(key) ? store[key] : '0;
                    rd_pend <= T_CL;
                end
                CMD_WRITE: begin
                    check_access();
                    word = store.exists(key) ? store[key] : '0;
                    // dm high masks the byte
                    for (int i = 0; i < STRB_W; i++) begin
                        if (!dram_dm[i]) begin
                            word[8*i +: 8] = dram_dq[8*i +: 8];
                        end
                    end
                    store[key] = word;
                    wr_cyc = cyc;
                end
                CMD_PRECHARGE: begin
                    if (!bank_open[dram_ba]) begin
                        report_violation("PRECHARGE to a bank that is not open");
                    end
                    if (cyc - wr_cyc < T_WR) begin
                        report_violation("PRECHARGE less than tWR after WRITE");
                    end
                    bank_open[dram_ba] = 1'b0;
                    pre_cyc = cyc;
                end
                default: report_violation("unknown command on the DRAM pins");
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== bench/tb_soc_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_soc_top
    import axi_pkg::*;
    import dram_pkg::*;
();

    localparam int N_ROWS   = 12;
    localparam int N_RAND   = 24;
    localparam int CLK_NS   = 40;
    localparam int RESET_NS = 4 * CLK_NS;
    // 30 cycles per access is far above the DRAM path latency
    localparam int WATCHDOG_NS = RESET_NS + (N_ROWS + 2 * N_RAND) * 30 * CLK_NS;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        logic [STRB_W-1:0] strb;
        logic [DATA_W-1:0] exp_rdata;
        logic              exp_error;
    } vector_t;

    logic              clk;
    logic              rst_n;
    logic              mem_valid;
    logic [ADDR_W-1:0] mem_addr;
    logic [DATA_W-1:0] mem_wdata;
    logic [STRB_W-1:0] mem_wstrb;
    wire               mem_ready;
    wire [DATA_W-1:0]  mem_rdata;
    wire               mem_error;
    wire               dram_ck;
    wire               dram_cs;
    wire               dram_ras;
    wire               dram_cas;
    wire               dram_we;
    wire [ROW_W-1:0]   dram_addr;
    wire [BANK_W-1:0]  dram_ba;
    wire [DATA_W-1:0]  dram_dq;
    wire [STRB_W-1:0]  dram_dm;
    int                violations;
    int                act_count;

    vector_t           vectors [N_ROWS];
    logic [ADDR_W-1:0] rand_addr [N_RAND];
    logic [DATA_W-1:0] ref_mem [logic [ADDR_W-1:0]];
    integer            seed = 46;
    int                mismatches = 0;
    int                other_errors = 0;

    soc_top DUT (
        .clk(clk), .rst_n(rst_n),
        .mem_valid(mem_valid), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_wstrb(mem_wstrb),
        .mem_ready(mem_ready), .mem_rdata(mem_rdata), .mem_error(mem_error),
        .dram_ck(dram_ck), .dram_cs(dram_cs), .dram_ras(dram_ras),
        .dram_cas(dram_cas), .dram_we(dram_we),
        .dram_addr(dram_addr), .dram_ba(dram_ba),
        .dram_dq(dram_dq), .dram_dm(dram_dm)
    );

    dram_model dram (
        .dram_ck(dram_ck), .rst_n(rst_n),
        .dram_cs(dram_cs), .dram_ras(dram_ras), .dram_cas(dram_cas), .dram_we(dram_we),
        .dram_addr(dram_addr), .dram_ba(dram_ba),
        .dram_dq(dram_dq), .dram_dm(dram_dm),
        .violations(violations), .act_count(act_count)
    );

    always #(CLK_NS / 2) clk = ~clk;

    task automatic load_table();
        // addr, wdata, strb, expected rdata, expected error
        vectors[0]  = {32'h0000_0100, 32'hDEAD_BEEF, 4'hF, 32'h0000_0000, 1'b0};
        vectors[1]  = {32'h0000_0100, 32'h0000_0000, 4'h0, 32'hDEAD_BEEF, 1'b0};
        // Bytes 0 and 2 replaced
        vectors[2]  = {32'h0000_0100, 32'h1122_3344, 4'h5, 32'h0000_0000, 1'b0};
        vectors[3]  = {32'h0000_0100, 32'h0000_0000, 4'h0, 32'hDE22_BE44, 1'b0};
        vectors[4]  = {32'h0123_4568, 32'hA5A5_A5A5, 4'h8, 32'h0000_0000, 1'b0};
        vectors[5]  = {32'h0123_4568, 32'h0000_0000, 4'h0, 32'hA500_0000, 1'b0};
        // Out of range, decode error
        vectors[6]  = {32'h2000_0000, 32'h0000_0000, 4'h0, 32'h0000_0000, 1'b1};
        vectors[7]  = {32'hFFFF_FFF0, 32'h5555_AAAA, 4'hF, 32'h0000_0000, 1'b1};
        vectors[8]  = {32'h8000_0004, 32'h0000_0000, 4'h0, 32'h0000_0000, 1'b1};
        // Last DRAM word
        vectors[9]  = {32'h1FFF_FFFC, 32'h0000_0000, 4'h0, 32'h0000_0000, 1'b0};
        vectors[10] = {32'h1FFF_FFFC, 32'h0BAD_F00D, 4'h3, 32'h0000_0000, 1'b0};
        vectors[11] = {32'h1FFF_FFFC, 32'h0000_0000, 4'h0, 32'h0000_F00D, 1'b0};
    endtask

    task automatic check_word(input string name, input logic [DATA_W-1:0] expected,
                              input logic [DATA_W-1:0] actual);
        if (actual !== expected) begin
            $display("mismatch at %0d ns: %s expected %h, got %h",
                     $time, name, expected, actual);
            mismatches++;
        end
    endtask

    // One request, held until the ready pulse
    task automatic mem_access(input logic [ADDR_W-1:0] addr,
                              input logic [DATA_W-1:0] wdata,
                              input logic [STRB_W-1:0] strb,
                              output logic [DATA_W-1:0] rdata,
                              output logic error);
        @(posedge clk);
        mem_valid <= 1'b1;
        mem_addr  <= addr;
        mem_wdata <= wdata;
        mem_wstrb <= strb;
        do begin
            @(posedge clk);
        end while (mem_ready !== 1'b1);
        rdata = mem_rdata;
        error = mem_error;
        mem_valid <= 1'b0;
    endtask

    task automatic print_counts();
        $display("mismatches: %0d, other errors: %0d, protocol violations: %0d",
                 mismatches, other_errors, violations);
    endtask

    initial begin
        logic [DATA_W-1:0] rdata;
        logic              error;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
        int                act_before;

        clk       = 1'b0;
        rst_n     = 1'b0;
        mem_valid = 1'b0;
        mem_addr  = '0;
        mem_wdata = '0;
        mem_wstrb = '0;
        load_table();
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        check_word("mem_ready", 0, mem_ready);
        if (dram_dq !== {DATA_W{1'bz}}) begin
            $display("error at %0d ns: dram_dq is driven right after reset", $time);
            other_errors++;
        end

        for (int i = 0; i < N_ROWS; i++) begin
            act_before = act_count;
            mem_access(vectors[i].addr, vectors[i].wdata, vectors[i].strb, rdata, error);
            check_word("mem_error", vectors[i].exp_error, error);
            if (vectors[i].strb == '0) begin
                check_word("mem_rdata", vectors[i].exp_rdata, rdata);
            end
            // An out-of-range access must never reach the DRAM pins
            if (vectors[i].exp_error && act_count != act_before) begin
                $display("error at %0d ns: ACTIVATE issued during access to %h",
                         $time, vectors[i].addr);
                other_errors++;
            end
        end

        // Random words across banks and rows
        for (int i = 0; i < N_RAND; i++) begin
            addr = $random(seed);
            data = $random(seed);
            addr = {3'b000, addr[28:2], 2'b00};
            rand_addr[i]  = addr;
            ref_mem[addr] = data;
            mem_access(addr, data, '1, rdata, error);
            check_word("mem_error", 0, error);
        end
        for (int i = 0; i < N_RAND; i++) begin
            mem_access(rand_addr[i], '0, '0, rdata, error);
            check_word("mem_rdata", ref_mem[rand_addr[i]], rdata);
            check_word("mem_error", 0, error);
        end

        // Let the last precharge go out
        repeat (4) @(posedge clk);
        print_counts();
        if (mismatches == 0 && other_errors == 0 && violations == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: run did not finish within %0d ns", WATCHDOG_NS);
        print_counts();
        $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
src/axi_pkg.sv
src/dram_pkg.sv
src/mem_axi_bridge.sv
src/axi_interconnect.sv
src/dram_controller.sv
src/soc_top.sv
bench/dram_model.sv
bench/tb_soc_top.sv
